// ==== sch_pkg.sv ====
// mode codes, ID field and debug state codes; the debug code holds pipe k as k+1, so at most 15 pipes
`default_nettype none

package sch_pkg;

   // aggregation mode select
   localparam int MODE_W = 2;

   // line-granular grants, one pipe at a time
   localparam logic [MODE_W-1:0] MODE_SYNC = 2'd2;

   // ID-matched words pass without a grant
   localparam logic [MODE_W-1:0] MODE_ASYNC = 2'd3;

   // aggregator ID sits in the top bits of each data word
   localparam int ID_W = 4;

   // debug state width
   localparam int STATE_W = 4;

   // no pipe granted since reset
   localparam logic [STATE_W-1:0] STATE_IDLE = 4'd0;

endpackage

`default_nettype wire

// ==== sch_req_stage.sv ====
// requests only exist in sync mode; line_end must be a pulse from the pipe's own fifo read side
`default_nettype none

module sch_req_stage #(
   parameter int NUM_PIPES = 8
) (
   input  wire                           aggre_clk,
   input  wire                           aggre_clk_rst_n,
   input  wire  [sch_pkg::MODE_W-1:0]    aggre_mode,
   input  wire  [NUM_PIPES-1:0]          aggre_en,
   input  wire  [NUM_PIPES-1:0]          empty,
   input  wire  [NUM_PIPES-1:0]          line_end,
   output logic [NUM_PIPES-1:0]          req_q,
   output logic [NUM_PIPES-1:0]          line_end_q
);

   logic                 sync_mode;
   logic [NUM_PIPES-1:0] req_d;

   assign sync_mode = (aggre_mode == sch_pkg::MODE_SYNC);

   // a pipe wants the output when enabled and its fifo holds data
   always_comb begin
      if (sync_mode) begin
         req_d = aggre_en & ~empty;
      end else begin
         req_d = '0;
      end
   end

   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         req_q <= '0;
      end else begin
         req_q <= req_d;
      end
   end

   // line ends are kept in step with the requests
   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         line_end_q <= '0;
      end else begin
         line_end_q <= line_end;
      end
   end

endmodule

`default_nettype wire

// ==== sch_line_arbiter.sv ====
// round-robin grant held for a whole line; only the granted pipe's line end frees it, one idle cycle between grants
`default_nettype none

module sch_line_arbiter #(
   parameter int NUM_PIPES = 8
) (
   input  wire                   aggre_clk,
   input  wire                   aggre_clk_rst_n,
   input  wire  [NUM_PIPES-1:0]  req_q,
   input  wire  [NUM_PIPES-1:0]  line_end_q,
   output logic [NUM_PIPES-1:0]  up_state,
   output logic                  aggre_busy
);

   localparam int IDX_W = (NUM_PIPES > 1) ? $clog2(NUM_PIPES) : 1;

   // one-hot seed for building the grant
   localparam logic [NUM_PIPES-1:0] ONE_HOT_0 = {{(NUM_PIPES-1){1'b0}}, 1'b1};

   logic [IDX_W-1:0] last_idx;
   logic [IDX_W-1:0] next_idx;
   logic             next_found;
   logic             release_grant;

   // search starts just above the last served pipe and wraps
   always_comb begin
      int cand;

      cand       = 0;
      next_idx   = last_idx;
      next_found = 1'b0;
      for (int off = 1; off <= NUM_PIPES; off++) begin
         cand = (int'(last_idx) + off) % NUM_PIPES;
         if (!next_found && req_q[cand]) begin
            next_found = 1'b1;
            next_idx   = IDX_W'(cand);
         end
      end
   end

   // line ends of other pipes do not matter here
   assign release_grant = |(up_state & line_end_q);

   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         up_state <= '0;
      end else if (|up_state) begin
         // held until line end, even if the request drops
         if (release_grant) begin
            up_state <= '0;
         end
      end else if (next_found) begin
         up_state <= ONE_HOT_0 << next_idx;
      end
   end

   // reset value makes pipe 0 the first one searched
   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         last_idx <= IDX_W'(NUM_PIPES - 1);
      end else if (!(|up_state) && next_found) begin
         last_idx <= next_idx;
      end
   end

   assign aggre_busy = |up_state;

endmodule

`default_nettype wire

// ==== sch_data_select.sv ====
// one cycle from input to output, no stall; losing or ungranted words are dropped, data is zero when not valid
`default_nettype none

module sch_data_select #(
   parameter int          NUM_PIPES = 8,
   parameter int          DATA_W    = 140,
   parameter logic [1:0]  AGGR_ID   = 2'd0
) (
   input  wire                                aggre_clk,
   input  wire                                aggre_clk_rst_n,
   input  wire  [sch_pkg::MODE_W-1:0]         aggre_mode,
   input  wire  [NUM_PIPES-1:0]               up_state,
   input  wire  [NUM_PIPES-1:0]               in_video_data_vld,
   input  wire  [NUM_PIPES-1:0][DATA_W-1:0]   in_video_data,
   output logic                               out_video_data_vld,
   output logic [DATA_W-1:0]                  out_video_data
);

   // aggregator ID, zero extended to the field width
   localparam logic [sch_pkg::ID_W-1:0] MATCH_ID = sch_pkg::ID_W'(AGGR_ID);

   logic [NUM_PIPES-1:0] id_match;
   logic [NUM_PIPES-1:0] grant_hit;
   logic                 async_vld;
   logic [DATA_W-1:0]    async_data;
   logic                 sync_vld;
   logic [DATA_W-1:0]    sync_data;
   logic                 sel_vld;
   logic [DATA_W-1:0]    sel_data;

   always_comb begin
      for (int i = 0; i < NUM_PIPES; i++) begin
         id_match[i] = in_video_data_vld[i] &&
                       (in_video_data[i][DATA_W-1 -: sch_pkg::ID_W] == MATCH_ID);
      end
   end

   assign grant_hit = in_video_data_vld & up_state;

   // walk down so the lowest pipe index wins a collision
   always_comb begin
      async_vld  = 1'b0;
      async_data = '0;
      for (int i = NUM_PIPES - 1; i >= 0; i--) begin
         if (id_match[i]) begin
            async_vld  = 1'b1;
            async_data = in_video_data[i];
         end
      end
   end

   // grant is one-hot, so at most one hit
   always_comb begin
      sync_vld  = 1'b0;
      sync_data = '0;
      for (int i = NUM_PIPES - 1; i >= 0; i--) begin
         if (grant_hit[i]) begin
            sync_vld  = 1'b1;
            sync_data = in_video_data[i];
         end
      end
   end

   // every branch leaves the data at zero when nothing is selected
   always_comb begin
      case (aggre_mode)
         sch_pkg::MODE_ASYNC: begin
            sel_vld  = async_vld;
            sel_data = async_data;
         end
         sch_pkg::MODE_SYNC: begin
            sel_vld  = sync_vld;
            sel_data = sync_data;
         end
         default: begin
            sel_vld  = 1'b0;
            sel_data = '0;
         end
      endcase
   end

   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         out_video_data_vld <= 1'b0;
         out_video_data     <= '0;
      end else begin
         out_video_data_vld <= sel_vld;
         out_video_data     <= sel_data;
      end
   end

endmodule

`default_nettype wire

// ==== sch_state_monitor.sv ====
// debug only; shows the last granted pipe as index plus one and reads IDLE only until the first grant
`default_nettype none

module sch_state_monitor #(
   parameter int NUM_PIPES = 8
) (
   input  wire                            aggre_clk,
   input  wire                            aggre_clk_rst_n,
   input  wire  [NUM_PIPES-1:0]           up_state,
   output logic [sch_pkg::STATE_W-1:0]    sch_current_state
);

   logic [sch_pkg::STATE_W-1:0] grant_code;

   // lowest set bit wins, grant is one-hot anyway
   always_comb begin
      grant_code = sch_pkg::STATE_IDLE;
      for (int i = NUM_PIPES - 1; i >= 0; i--) begin
         if (up_state[i]) begin
            grant_code = sch_pkg::STATE_W'(i + 1);
         end
      end
   end

   // holds between grants
   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         sch_current_state <= sch_pkg::STATE_IDLE;
      end else if (|up_state) begin
         sch_current_state <= grant_code;
      end
   end

endmodule

`default_nettype wire

// ==== pipe_sch_top.sv ====
// modes 2 and 3 only, modes 0 and 1 give no output; NUM_PIPES 2..15, DATA_W must hold the 4-bit ID field
`default_nettype none

module pipe_sch_top #(
   parameter int          NUM_PIPES = 8,
   parameter int          DATA_W    = 140,
   parameter logic [1:0]  AGGR_ID   = 2'd0
) (
   input  wire                                aggre_clk,
   input  wire                                aggre_clk_rst_n,
   input  wire  [sch_pkg::MODE_W-1:0]         aggre_mode,
   input  wire  [NUM_PIPES-1:0]               aggre_en,
   input  wire  [NUM_PIPES-1:0]               empty,
   input  wire  [NUM_PIPES-1:0]               line_end,
   input  wire  [NUM_PIPES-1:0]               in_video_data_vld,
   input  wire  [NUM_PIPES-1:0][DATA_W-1:0]   in_video_data,
   output logic [NUM_PIPES-1:0]               up_state,
   output logic                               out_video_data_vld,
   output logic [DATA_W-1:0]                  out_video_data,
   output logic                               aggre_busy,
   output logic [sch_pkg::STATE_W-1:0]        sch_current_state
);

   logic [NUM_PIPES-1:0] req_q;
   logic [NUM_PIPES-1:0] line_end_q;

   sch_req_stage #(
      .NUM_PIPES (NUM_PIPES)
   ) u_req_stage (
      .aggre_clk       (aggre_clk),
      .aggre_clk_rst_n (aggre_clk_rst_n),
      .aggre_mode      (aggre_mode),
      .aggre_en        (aggre_en),
      .empty           (empty),
      .line_end        (line_end),
      .req_q           (req_q),
      .line_end_q      (line_end_q)
   );

   sch_line_arbiter #(
      .NUM_PIPES (NUM_PIPES)
   ) u_line_arbiter (
      .aggre_clk       (aggre_clk),
      .aggre_clk_rst_n (aggre_clk_rst_n),
      .req_q           (req_q),
      .line_end_q      (line_end_q),
      .up_state        (up_state),
      .aggre_busy      (aggre_busy)
   );

   // data bypasses the request stage, so the output trails the input by one cycle
   sch_data_select #(
      .NUM_PIPES (NUM_PIPES),
      .DATA_W    (DATA_W),
      .AGGR_ID   (AGGR_ID)
   ) u_data_select (
      .aggre_clk          (aggre_clk),
      .aggre_clk_rst_n    (aggre_clk_rst_n),
      .aggre_mode         (aggre_mode),
      .up_state           (up_state),
      .in_video_data_vld  (in_video_data_vld),
      .in_video_data      (in_video_data),
      .out_video_data_vld (out_video_data_vld),
      .out_video_data     (out_video_data)
   );

   sch_state_monitor #(
      .NUM_PIPES (NUM_PIPES)
   ) u_state_monitor (
      .aggre_clk         (aggre_clk),
      .aggre_clk_rst_n   (aggre_clk_rst_n),
      .up_state          (up_state),
      .sch_current_state (sch_current_state)
   );

endmodule

`default_nettype wire

// ==== tb_pipe_sch.sv ====
// runs the DUT with default parameters only (8 pipes, 140-bit words, aggregator ID 0)
`default_nettype none

module tb_pipe_sch;

   localparam int         NUM_PIPES    = 8;
   localparam int         DATA_W       = 140;
   localparam logic [1:0] AGGR_ID      = 2'd0;
   localparam int         CLK_PERIOD   = 4;
   localparam int         RESET_CYCLES = 10;
   localparam int         ASYNC_CYCLES = 300;
   localparam int         SYNC_CYCLES  = 400;
   localparam int         DRAIN_CYCLES = 8;
   localparam int         IDLE_CYCLES  = 100;
   localparam int         TOTAL_CYCLES = RESET_CYCLES + ASYNC_CYCLES + SYNC_CYCLES +
                                         DRAIN_CYCLES + IDLE_CYCLES + 4;

   logic                             aggre_clk;
   logic                             aggre_clk_rst_n;
   logic [sch_pkg::MODE_W-1:0]       aggre_mode;
   logic [NUM_PIPES-1:0]             aggre_en;
   logic [NUM_PIPES-1:0]             empty;
   logic [NUM_PIPES-1:0]             line_end;
   logic [NUM_PIPES-1:0]             in_video_data_vld;
   logic [NUM_PIPES-1:0][DATA_W-1:0] in_video_data;
   logic [NUM_PIPES-1:0]             up_state;
   logic                             out_video_data_vld;
   logic [DATA_W-1:0]                out_video_data;
   logic                             aggre_busy;
   logic [sch_pkg::STATE_W-1:0]      sch_current_state;

   integer seed        = 32'h69a9_3a5e;
   int     fail_count  = 0;
   int     grant_count = 0;
   int     async_hits  = 0;

   // cycle model of the scheduler
   logic [NUM_PIPES-1:0]             m_req_q;
   logic [NUM_PIPES-1:0]             m_le_q;
   logic [NUM_PIPES-1:0]             m_up;
   int                               m_last;
   logic                             m_out_vld;
   logic [DATA_W-1:0]                m_out_data;
   logic [sch_pkg::STATE_W-1:0]      m_state;

   // inputs as they stood at the last rising edge
   logic [sch_pkg::MODE_W-1:0]       p_mode;
   logic [NUM_PIPES-1:0]             p_en;
   logic [NUM_PIPES-1:0]             p_empty;
   logic [NUM_PIPES-1:0]             p_line_end;
   logic [NUM_PIPES-1:0]             p_vld;
   logic [NUM_PIPES-1:0][DATA_W-1:0] p_data;

   pipe_sch_top DUT (
      .aggre_clk          (aggre_clk),
      .aggre_clk_rst_n    (aggre_clk_rst_n),
      .aggre_mode         (aggre_mode),
      .aggre_en           (aggre_en),
      .empty              (empty),
      .line_end           (line_end),
      .in_video_data_vld  (in_video_data_vld),
      .in_video_data      (in_video_data),
      .up_state           (up_state),
      .out_video_data_vld (out_video_data_vld),
      .out_video_data     (out_video_data),
      .aggre_busy         (aggre_busy),
      .sch_current_state  (sch_current_state)
   );

   initial begin
      aggre_clk = 1'b0;
      forever #(CLK_PERIOD / 2) aggre_clk = ~aggre_clk;
   end

   task automatic check_value(input string name, input logic [159:0] actual,
                              input logic [159:0] expected);
      if (actual !== expected) begin
         fail_count++;
         $display("Error: %s is %0h, expected %0h at time %0t", name, actual, expected, $time);
         $display("Test failures found");
         $fatal(1);
      end
   endtask

   // lowest pipe whose valid word carries the aggregator ID
   function automatic logic [DATA_W:0] expected_async(
      input logic [NUM_PIPES-1:0]             vld,
      input logic [NUM_PIPES-1:0][DATA_W-1:0] data
   );
      for (int i = 0; i < NUM_PIPES; i++) begin
         if (vld[i] && data[i][DATA_W-1 -: sch_pkg::ID_W] == sch_pkg::ID_W'(AGGR_ID)) begin
            return {1'b1, data[i]};
         end
      end
      return '0;
   endfunction

   // next requester above the last grant, wrapping; -1 when none
   function automatic int expected_grant(input int last, input logic [NUM_PIPES-1:0] req);
      int cand;

      for (int off = 1; off <= NUM_PIPES; off++) begin
         cand = (last + off) % NUM_PIPES;
         if (req[cand]) begin
            return cand;
         end
      end
      return -1;
   endfunction

   always @(posedge aggre_clk) begin
      logic [DATA_W:0] async_pick;
      int              g;

      p_mode     = aggre_mode;
      p_en       = aggre_en;
      p_empty    = empty;
      p_line_end = line_end;
      p_vld      = in_video_data_vld;
      p_data     = in_video_data;
      if (!aggre_clk_rst_n) begin
         m_req_q    = '0;
         m_le_q     = '0;
         m_up       = '0;
         m_last     = NUM_PIPES - 1;
         m_out_vld  = 1'b0;
         m_out_data = '0;
         m_state    = sch_pkg::STATE_IDLE;
      end else begin
         m_out_vld  = 1'b0;
         m_out_data = '0;
         if (p_mode == sch_pkg::MODE_ASYNC) begin
            async_pick = expected_async(p_vld, p_data);
            m_out_vld  = async_pick[DATA_W];
            m_out_data = async_pick[DATA_W-1:0];
            if (m_out_vld) begin
               async_hits++;
            end
         end else if (p_mode == sch_pkg::MODE_SYNC) begin
            for (int i = 0; i < NUM_PIPES; i++) begin
               if (m_up[i] && p_vld[i]) begin
                  m_out_vld  = 1'b1;
                  m_out_data = p_data[i];
               end
            end
         end
         for (int i = 0; i < NUM_PIPES; i++) begin
            if (m_up[i]) begin
               m_state = sch_pkg::STATE_W'(i + 1);
            end
         end
         // grant held for the line, then one free cycle
         if (m_up != '0) begin
            if ((m_up & m_le_q) != '0) begin
               m_up = '0;
            end
         end else begin
            g = expected_grant(m_last, m_req_q);
            if (g >= 0) begin
               m_up       = '0;
               m_up[g]    = 1'b1;
               m_last     = g;
               grant_count++;
            end
         end
         m_req_q = (p_mode == sch_pkg::MODE_SYNC) ? (p_en & ~p_empty) : '0;
         m_le_q  = p_line_end;
      end
      #1;
      check_value("up_state", up_state, m_up);
      check_value("aggre_busy", aggre_busy, m_up != '0);
      check_value("out_video_data_vld", out_video_data_vld, m_out_vld);
      check_value("out_video_data", out_video_data, m_out_data);
      check_value("sch_current_state", sch_current_state, m_state);
   end

   // top ID field 0..5, so roughly one word in six matches
   task automatic random_words();
      logic [159:0] wide;

      for (int i = 0; i < NUM_PIPES; i++) begin
         wide = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
         in_video_data[i] = wide[DATA_W-1:0];
         in_video_data[i][DATA_W-1 -: sch_pkg::ID_W] = sch_pkg::ID_W'({$random(seed)} % 6);
      end
      in_video_data_vld = NUM_PIPES'($random(seed));
   endtask

   task automatic run_async(input int cycles);
      repeat (cycles) begin
         @(negedge aggre_clk);
         aggre_mode = sch_pkg::MODE_ASYNC;
         aggre_en   = NUM_PIPES'($random(seed));
         empty      = NUM_PIPES'($random(seed));
         line_end   = NUM_PIPES'($random(seed));
         random_words();
      end
   endtask

   task automatic run_sync(input int cycles);
      int r;

      repeat (cycles) begin
         @(negedge aggre_clk);
         aggre_mode = sch_pkg::MODE_SYNC;
         aggre_en   = ~(NUM_PIPES'($random(seed)) & NUM_PIPES'($random(seed)));
         empty      = NUM_PIPES'($random(seed)) & NUM_PIPES'($random(seed));
         line_end   = '0;
         r = {$random(seed)} % 8;
         // line end on the granted pipe, or a stray one elsewhere
         if (r < 2) begin
            line_end = m_up;
         end else if (r == 2) begin
            line_end = NUM_PIPES'(1) << ({$random(seed)} % NUM_PIPES);
         end
         random_words();
      end
   endtask

   // stop requests, then end every line so no grant is left
   task automatic drain_grants();
      repeat (4) begin
         @(negedge aggre_clk);
         empty             = '1;
         line_end          = '0;
         in_video_data_vld = '0;
      end
      @(negedge aggre_clk);
      line_end = '1;
      repeat (3) begin
         @(negedge aggre_clk);
         line_end = '0;
      end
   endtask

   task automatic run_idle_modes(input int cycles);
      repeat (cycles) begin
         @(negedge aggre_clk);
         check_value("up_state", up_state, '0);
         check_value("out_video_data_vld", out_video_data_vld, 1'b0);
         aggre_mode = sch_pkg::MODE_W'({$random(seed)} % 2);
         aggre_en   = NUM_PIPES'($random(seed));
         empty      = NUM_PIPES'($random(seed));
         line_end   = NUM_PIPES'($random(seed));
         random_words();
      end
   endtask

   initial begin
      aggre_clk_rst_n   = 1'b0;
      aggre_mode        = '0;
      aggre_en          = '0;
      empty             = '1;
      line_end          = '0;
      in_video_data_vld = '0;
      in_video_data     = '0;
      repeat (RESET_CYCLES) @(negedge aggre_clk);
      aggre_clk_rst_n = 1'b1;
      run_async(ASYNC_CYCLES);
      run_sync(SYNC_CYCLES);
      drain_grants();
      run_idle_modes(IDLE_CYCLES);
      @(negedge aggre_clk);
      check_value("sync grant count above two rounds", grant_count >= 2 * NUM_PIPES, 1'b1);
      check_value("async matched words seen", async_hits > 0, 1'b1);
      if (fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(TOTAL_CYCLES * 2 * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles", TOTAL_CYCLES * 2);
      $display("Test failures found");
      $fatal(1);
   end

endmodule

`default_nettype wire

// ==== all.f ====
sch_pkg.sv
sch_req_stage.sv
sch_line_arbiter.sv
sch_data_select.sv
sch_state_monitor.sv
pipe_sch_top.sv
tb_pipe_sch.sv
